/* include/rrf_defines.svh */
// Recovery register file global sizes
// Address, data and codeword widths, bank depth and the ECC switch
// shared by the package and every RTL block

`ifndef RRF_DEFINES_SVH
`define RRF_DEFINES_SVH

// Register address, bit 5 picks the FP bank
`define RRF_ADDR_WIDTH 6

// Architectural data word
`define RRF_DATA_WIDTH 32

// SECDED codeword, data plus check bits
`define RRF_CODE_WIDTH 39
`define RRF_CHECK_WIDTH 7

// Words per bank, integer and FP alike
`define RRF_NUM_WORDS 32

// 1 keeps codewords in storage, 0 keeps plain data
`define RRF_ECC_ENABLE 1

// Width of one stored word, follows the ECC switch
`define RRF_STORE_WIDTH ((`RRF_ECC_ENABLE) ? `RRF_CODE_WIDTH : `RRF_DATA_WIDTH)

`endif

/* logic/rrf_pkg.sv */
// Recovery register file types
// Port structs, the codeword union and the SECDED column matrix

`include "rrf_defines.svh"

package rrf_pkg;

  // Write-back port from the core
  typedef struct packed {
    logic                       we;
    logic [`RRF_ADDR_WIDTH-1:0] addr;
    logic [`RRF_DATA_WIDTH-1:0] data;
  } rf_write_t;

  // Decoded read result with ECC status
  typedef struct packed {
    logic [`RRF_DATA_WIDTH-1:0] data;
    logic                       corrected;
    logic                       uncorrectable;
  } rf_rdata_t;

  // One replayed register towards the core
  typedef struct packed {
    logic                       valid;
    logic [`RRF_ADDR_WIDTH-1:0] addr;
    logic [`RRF_DATA_WIDTH-1:0] data;
  } rf_restore_t;

  // Check bits sit above the data
  typedef struct packed {
    logic [`RRF_CHECK_WIDTH-1:0] check;
    logic [`RRF_DATA_WIDTH-1:0]  data;
  } ecc_fields_t;

  // Codeword seen as raw storage bits or as its fields
  typedef union packed {
    logic [`RRF_CODE_WIDTH-1:0] raw;
    ecc_fields_t                fields;
  } ecc_word_u;

  // H matrix, one check column per data bit
  typedef logic [`RRF_DATA_WIDTH-1:0][`RRF_CHECK_WIDTH-1:0] ecc_cols_t;

  // Hsiao columns: the first 32 weight-3 patterns in ascending order
  // Check bits themselves form the weight-1 identity part
  function automatic ecc_cols_t ecc_h_matrix();
    ecc_cols_t   cols;
    int unsigned n;
    cols = '0;
    n    = 0;
    for (int unsigned v = 0; v < (1 << `RRF_CHECK_WIDTH); v++) begin
      if (($countones(v) == 3) && (n < `RRF_DATA_WIDTH)) begin
        cols[n] = `RRF_CHECK_WIDTH'(v);
        n++;
      end
    end
    return cols;
  endfunction

endpackage

/* logic/secded_39_32_enc.sv */
// Hsiao SECDED encoder, 32 data bits into a 39-bit codeword
// Each check bit is the parity of the data bits whose column has it set

`timescale 1ns/100ps
`include "rrf_defines.svh"

module secded_39_32_enc import rrf_pkg::*; (
  input  logic [`RRF_DATA_WIDTH-1:0] data_i,
  output ecc_word_u                  code_o
);

  // Odd-weight columns shared with the decoder
  localparam ecc_cols_t HCols = ecc_h_matrix();

  // ------------------------------------------------
  // Check bit generation
  // ------------------------------------------------

  logic [`RRF_CHECK_WIDTH-1:0] check;

  // XOR in the column of every set data bit
  // Unrolls into one parity tree per check bit
  always_comb begin
    check = '0;
    for (int i = 0; i < `RRF_DATA_WIDTH; i++) begin
      if (data_i[i]) begin
        check ^= HCols[i];
      end
    end
  end

  // ------------------------------------------------
  // Codeword assembly
  // ------------------------------------------------

  // Data stays in the low bits, check bits on top
  always_comb begin
    code_o.fields.check = check;
    code_o.fields.data  = data_i;
  end

endmodule

/* logic/secded_39_32_dec.sv */
// Hsiao SECDED decoder for 39-bit codewords
// Recomputes the syndrome, repairs any single flipped bit
// and flags double errors as uncorrectable

`timescale 1ns/100ps
`include "rrf_defines.svh"

module secded_39_32_dec import rrf_pkg::*; (
  input  ecc_word_u code_i,
  output rf_rdata_t result_o
);

  // Same column set as the encoder
  localparam ecc_cols_t HCols = ecc_h_matrix();

  logic [`RRF_CHECK_WIDTH-1:0] syndrome;
  logic [`RRF_DATA_WIDTH-1:0]  flip;
  logic                        data_hit;
  logic                        check_hit;
  logic                        error;

  // ------------------------------------------------
  // Syndrome
  // ------------------------------------------------

  // Stored check bits against the ones rebuilt from the data
  always_comb begin
    syndrome = code_i.fields.check;
    for (int i = 0; i < `RRF_DATA_WIDTH; i++) begin
      if (code_i.fields.data[i]) begin
        syndrome ^= HCols[i];
      end
    end
  end

  // ------------------------------------------------
  // Error location
  // ------------------------------------------------

  // One comparator per data column
  // Columns are distinct so at most one bit of flip is set
  for (genvar i = 0; i < `RRF_DATA_WIDTH; i++) begin : gen_flip
    assign flip[i] = (syndrome == HCols[i]);
  end

  assign data_hit = |flip;

  // Weight 1 means a check bit flipped, data is intact
  assign check_hit = $onehot(syndrome);

  assign error = |syndrome;

  // ------------------------------------------------
  // Result
  // ------------------------------------------------

  // Single errors are repaired
  // Even weight is a double error, odd weight without a matching column
  // is beyond the code and gets the same flag
  assign result_o = '{
    data:          code_i.fields.data ^ flip,
    corrected:     data_hit | check_hit,
    uncorrectable: error & ~(data_hit | check_hit)
  };

endmodule

/* logic/recovery_rf.sv */
// Shadow register file for lockstep rapid recovery
// Two write-back ports mirror every core write into an integer bank
// and an FP bank, words held as SECDED codewords when ECC is on
// Four combinational read ports, the fourth belongs to the sequencer

`timescale 1ns/100ps
`include "rrf_defines.svh"

module recovery_rf import rrf_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Write-back ports, B wins on the same address
  input  rf_write_t                  wport_a_i,
  input  rf_write_t                  wport_b_i,
  // Core read addresses
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_a_i,
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_b_i,
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_c_i,
  // Recovery read address
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_r_i,
  output rf_rdata_t                  rdata_a_o,
  output rf_rdata_t                  rdata_b_o,
  output rf_rdata_t                  rdata_c_o,
  output rf_rdata_t                  rdata_r_o
);

  // Integer and FP banks
  logic [`RRF_STORE_WIDTH-1:0] int_bank_q [`RRF_NUM_WORDS];
  logic [`RRF_STORE_WIDTH-1:0] fp_bank_q  [`RRF_NUM_WORDS];

  // Words as they go into storage
  logic [`RRF_STORE_WIDTH-1:0] wword_a;
  logic [`RRF_STORE_WIDTH-1:0] wword_b;

  // One-hot enables over both banks, FP in the upper half
  logic [2*`RRF_NUM_WORDS-1:0] we_a_dec;
  logic [2*`RRF_NUM_WORDS-1:0] we_b_dec;

  // Read ports a, b, c and r in that order
  logic [`RRF_ADDR_WIDTH-1:0]  raddr [4];
  logic [`RRF_STORE_WIDTH-1:0] rword [4];
  rf_rdata_t                   rdata [4];

  // ------------------------------------------------
  // Write address decoder
  // ------------------------------------------------

  for (genvar w = 0; w < 2*`RRF_NUM_WORDS; w++) begin : gen_we_dec
    assign we_a_dec[w] = wport_a_i.we && (wport_a_i.addr == `RRF_ADDR_WIDTH'(w));
    assign we_b_dec[w] = wport_b_i.we && (wport_b_i.addr == `RRF_ADDR_WIDTH'(w));
  end

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RRF_NUM_WORDS; i++) begin
        int_bank_q[i] <= '0;
        fp_bank_q[i]  <= '0;
      end
    end else begin
      // Integer R0 is never written and stays zero
      for (int i = 1; i < `RRF_NUM_WORDS; i++) begin
        if (we_b_dec[i]) begin
          int_bank_q[i] <= wword_b;
        end else if (we_a_dec[i]) begin
          int_bank_q[i] <= wword_a;
        end
      end
      // FP R0 is an ordinary register
      for (int i = 0; i < `RRF_NUM_WORDS; i++) begin
        if (we_b_dec[i + `RRF_NUM_WORDS]) begin
          fp_bank_q[i] <= wword_b;
        end else if (we_a_dec[i + `RRF_NUM_WORDS]) begin
          fp_bank_q[i] <= wword_a;
        end
      end
    end
  end

  // ------------------------------------------------
  // Read muxes
  // ------------------------------------------------

  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;
  assign raddr[2] = raddr_c_i;
  assign raddr[3] = raddr_r_i;

  // Top address bit picks the bank, the rest the word
  for (genvar p = 0; p < 4; p++) begin : gen_rd_mux
    assign rword[p] = raddr[p][`RRF_ADDR_WIDTH-1]
                    ? fp_bank_q[raddr[p][`RRF_ADDR_WIDTH-2:0]]
                    : int_bank_q[raddr[p][`RRF_ADDR_WIDTH-2:0]];
  end

  // ------------------------------------------------
  // ECC codecs
  // ------------------------------------------------

  if (`RRF_ECC_ENABLE) begin : gen_ecc
    ecc_word_u code_a;
    ecc_word_u code_b;

    // Encode at the write ports
    secded_39_32_enc u_enc_a (
      .data_i ( wport_a_i.data ),
      .code_o ( code_a         )
    );

    secded_39_32_enc u_enc_b (
      .data_i ( wport_b_i.data ),
      .code_o ( code_b         )
    );

    assign wword_a = code_a.raw;
    assign wword_b = code_b.raw;

    // Decode only the words being read
    for (genvar p = 0; p < 4; p++) begin : gen_dec
      ecc_word_u rcode;

      assign rcode.raw = rword[p];

      secded_39_32_dec u_dec (
        .code_i   ( rcode    ),
        .result_o ( rdata[p] )
      );
    end
  end else begin : gen_plain
    assign wword_a = wport_a_i.data;
    assign wword_b = wport_b_i.data;

    // Plain storage never reports errors
    for (genvar p = 0; p < 4; p++) begin : gen_pass
      assign rdata[p] = '{data: rword[p], corrected: 1'b0, uncorrectable: 1'b0};
    end
  end

  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];
  assign rdata_c_o = rdata[2];
  assign rdata_r_o = rdata[3];

endmodule

/* logic/recovery_seq.sv */
// Recovery sequencer
// On a start pulse walks registers 1 to 63, one per cycle, and hands
// each corrected shadow word to the core as a restore write
// Done pulses once after the last register

`timescale 1ns/100ps
`include "rrf_defines.svh"

module recovery_seq import rrf_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       recovery_start_i,
  // Internal read port into the shadow file
  output logic [`RRF_ADDR_WIDTH-1:0] raddr_o,
  input  rf_rdata_t                  rdata_i,
  // Replay towards the core
  output rf_restore_t                restore_o,
  output logic                       busy_o,
  output logic                       done_o
);

  typedef enum logic {
    SeqIdle,
    SeqWalk
  } seq_state_e;

  seq_state_e                 state_q;
  seq_state_e                 state_d;
  logic [`RRF_ADDR_WIDTH-1:0] addr_q;
  logic [`RRF_ADDR_WIDTH-1:0] addr_d;
  logic                       done_q;
  logic                       done_d;
  logic                       last_addr;

  // Register 63, the final FP register
  assign last_addr = (addr_q == {`RRF_ADDR_WIDTH{1'b1}});

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    done_d  = 1'b0;
    case (state_q)
      SeqIdle: begin
        // Integer R0 is zero by definition, start at 1
        if (recovery_start_i) begin
          state_d = SeqWalk;
          addr_d  = `RRF_ADDR_WIDTH'(1);
        end
      end
      SeqWalk: begin
        // Start pulses are ignored while walking
        if (last_addr) begin
          state_d = SeqIdle;
          addr_d  = '0;
          done_d  = 1'b1;
        end else begin
          addr_d = addr_q + `RRF_ADDR_WIDTH'(1);
        end
      end
      default: begin
        state_d = SeqIdle;
        addr_d  = '0;
      end
    endcase
  end

  // ------------------------------------------------
  // State registers
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SeqIdle;
      addr_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      done_q  <= done_d;
    end
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------

  assign busy_o  = (state_q == SeqWalk);
  assign done_o  = done_q;
  assign raddr_o = addr_q;

  // Read is combinational, so data belongs to this cycle's address
  assign restore_o = '{valid: busy_o, addr: addr_q, data: rdata_i.data};

endmodule

/* logic/recovery_unit.sv */
// Rapid-recovery unit top level
// Shadow register file fed by the core's write-back ports, plus the
// sequencer that replays it after an error

`timescale 1ns/100ps
`include "rrf_defines.svh"

module recovery_unit import rrf_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Write-back from the core
  input  rf_write_t                  wport_a_i,
  input  rf_write_t                  wport_b_i,
  // Core read ports
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_a_i,
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_b_i,
  input  logic [`RRF_ADDR_WIDTH-1:0] raddr_c_i,
  output rf_rdata_t                  rdata_a_o,
  output rf_rdata_t                  rdata_b_o,
  output rf_rdata_t                  rdata_c_o,
  // Recovery control and replay
  input  logic                       recovery_start_i,
  output rf_restore_t                restore_o,
  output logic                       recovery_busy_o,
  output logic                       recovery_done_o
);

  // Sequencer read port into the shadow file
  logic [`RRF_ADDR_WIDTH-1:0] raddr_r;
  rf_rdata_t                  rdata_r;

  // ------------------------------------------------
  // Shadow register file
  // ------------------------------------------------

  recovery_rf u_rf (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .wport_a_i ( wport_a_i ),
    .wport_b_i ( wport_b_i ),
    .raddr_a_i ( raddr_a_i ),
    .raddr_b_i ( raddr_b_i ),
    .raddr_c_i ( raddr_c_i ),
    .raddr_r_i ( raddr_r   ),
    .rdata_a_o ( rdata_a_o ),
    .rdata_b_o ( rdata_b_o ),
    .rdata_c_o ( rdata_c_o ),
    .rdata_r_o ( rdata_r   )
  );

  // ------------------------------------------------
  // Replay sequencer
  // ------------------------------------------------

  recovery_seq u_seq (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .recovery_start_i ( recovery_start_i ),
    .raddr_o          ( raddr_r          ),
    .rdata_i          ( rdata_r          ),
    .restore_o        ( restore_o        ),
    .busy_o           ( recovery_busy_o  ),
    .done_o           ( recovery_done_o  )
  );

endmodule

/* bench/recovery_unit_assert.sv */
// Sequencer protocol checks bound into recovery_seq
// Walk order from register 1, done after exactly 63 restores, R0 never replayed

`timescale 1ns/100ps
`include "rrf_defines.svh"

module recovery_unit_assert import rrf_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input rf_restore_t restore_i,
  input logic        busy_i,
  input logic        done_i
);

  // Restores seen since the last done pulse
  logic [6:0] run_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else if (done_i) begin
      run_q <= '0;
    end else if (restore_i.valid) begin
      run_q <= run_q + 7'd1;
    end
  end

  // ------------------------------------------------
  // Properties
  // ------------------------------------------------

  // Walk starts at register 1 and steps by one each busy cycle
  walk_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_i |-> (restore_i.addr == ($past(busy_i)
                                   ? $past(restore_i.addr) + `RRF_ADDR_WIDTH'(1)
                                   : `RRF_ADDR_WIDTH'(1))))
    else $error("restore address out of order");

  // End of the walk is followed at once by done
  done_after_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(restore_i.valid) |-> done_i)
    else $error("done missing after last restore");

  done_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> (run_q == 7'd63 && !restore_i.valid))
    else $error("done without exactly 63 restores");

  no_r0_restore: assert property (@(posedge clk_i) disable iff (!rst_ni)
    restore_i.valid |-> (restore_i.addr != '0))
    else $error("integer R0 replayed");

endmodule

bind recovery_seq recovery_unit_assert u_seq_assert (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .restore_i ( restore_o ),
  .busy_i    ( busy_o    ),
  .done_i    ( done_o    )
);

/* bench/recovery_unit_tb.sv */
// Testbench for the rapid-recovery unit
// Table-driven writes and reads against a 64-word reference model,
// bit flips deposited into storage for ECC checks, then a full replay

`timescale 1ns/100ps
`include "rrf_defines.svh"

module recovery_unit_tb import rrf_pkg::*; ();

  // Each table row holds two writes, three reads and the flips injected at read port A
  typedef struct packed {
    logic       we_a;
    logic [5:0] addr_a;
    logic       we_b;
    logic [5:0] addr_b;
    logic [5:0] ra;
    logic [5:0] rb;
    logic [5:0] rc;
    logic [1:0] flips;
  } row_t;

  localparam int NumRows = 12;

  row_t stim [NumRows] = '{
    '{1'b1,  6'd5, 1'b1, 6'd40,  6'd5, 6'd40,  6'd0, 2'd0},
    '{1'b1, 6'd32, 1'b0,  6'd0, 6'd32,  6'd5, 6'd40, 2'd0},
    '{1'b1,  6'd0, 1'b1, 6'd63,  6'd0, 6'd63, 6'd32, 2'd0},
    '{1'b1, 6'd12, 1'b1, 6'd12, 6'd12, 6'd12, 6'd12, 2'd0},
    '{1'b1, 6'd45, 1'b1, 6'd45, 6'd45,  6'd0,  6'd5, 2'd0},
    '{1'b0,  6'd0, 1'b1,  6'd7,  6'd7,  6'd5, 6'd12, 2'd0},
    '{1'b1, 6'd20, 1'b0,  6'd0, 6'd20,  6'd7, 6'd45, 2'd1},
    '{1'b1, 6'd50, 1'b0,  6'd0, 6'd50, 6'd20, 6'd63, 2'd1},
    '{1'b0,  6'd0, 1'b0,  6'd0, 6'd12, 6'd50,  6'd7, 2'd2},
    '{1'b1, 6'd33, 1'b1, 6'd34, 6'd33, 6'd34, 6'd32, 2'd2},
    '{1'b1, 6'd31, 1'b1, 6'd62, 6'd31, 6'd62,  6'd0, 2'd0},
    '{1'b1,  6'd1, 1'b1,  6'd2,  6'd1,  6'd2,  6'd3, 2'd1}
  };

  logic        clk;
  logic        rst_n;
  rf_write_t   wport_a;
  rf_write_t   wport_b;
  logic [5:0]  raddr_a;
  logic [5:0]  raddr_b;
  logic [5:0]  raddr_c;
  rf_rdata_t   rdata_a;
  rf_rdata_t   rdata_b;
  rf_rdata_t   rdata_c;
  logic        start;
  rf_restore_t restore;
  logic        busy;
  logic        done;

  logic [31:0] model [64];
  logic [31:0] lcg_state;
  int          errors;
  int          tests;
  int          failed;

  recovery_unit dut0 (
    .clk_i            ( clk     ),
    .rst_ni           ( rst_n   ),
    .wport_a_i        ( wport_a ),
    .wport_b_i        ( wport_b ),
    .raddr_a_i        ( raddr_a ),
    .raddr_b_i        ( raddr_b ),
    .raddr_c_i        ( raddr_c ),
    .rdata_a_o        ( rdata_a ),
    .rdata_b_o        ( rdata_b ),
    .rdata_c_o        ( rdata_c ),
    .recovery_start_i ( start   ),
    .restore_o        ( restore ),
    .recovery_busy_o  ( busy    ),
    .recovery_done_o  ( done    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_port(input string name, input rf_rdata_t got, input logic [31:0] exp,
                            input logic corr, input logic unc, input logic use_data);
    assert ((!use_data || got.data == exp) && got.corrected == corr
            && got.uncorrectable == unc)
    else begin
      errors++;
      $display("Error %0t: %s got %h c%0b u%0b, expected %h c%0b u%0b", $time, name,
               got.data, got.corrected, got.uncorrectable, exp, corr, unc);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else begin
      errors++;
      $display("Error %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors > errs_before) begin
      failed++;
      $display("test %s: FAIL, %0d errors", name, errors - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // Reads are combinational so all 64 addresses fit in one clock period
  task automatic sweep_reads();
    for (int i = 0; i < 64; i++) begin
      raddr_a = 6'(i);
      raddr_b = 6'(i) + 6'd21;
      raddr_c = 6'(i) + 6'd42;
      #1;
      check_port("port a", rdata_a, model[raddr_a], 1'b0, 1'b0, 1'b1);
      check_port("port b", rdata_b, model[raddr_b], 1'b0, 1'b0, 1'b1);
      check_port("port c", rdata_c, model[raddr_c], 1'b0, 1'b0, 1'b1);
    end
  endtask

  function automatic logic [`RRF_STORE_WIDTH-1:0] stored_word(input logic [5:0] addr);
    if (addr[5]) begin
      return dut0.u_rf.fp_bank_q[addr[4:0]];
    end
    return dut0.u_rf.int_bank_q[addr[4:0]];
  endfunction

  task automatic deposit_word(input logic [5:0] addr, input logic [`RRF_STORE_WIDTH-1:0] word);
    if (addr[5]) begin
      dut0.u_rf.fp_bank_q[addr[4:0]] = word;
    end else begin
      dut0.u_rf.int_bank_q[addr[4:0]] = word;
    end
  endtask

  // ------------------------------------------------
  // Watchdog
  // ------------------------------------------------

  initial begin
    repeat (NumRows + 200) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", NumRows + 200);
    $display("sim failed");
    $finish;
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  initial begin
    row_t                        row;
    logic [31:0]                 da;
    logic [31:0]                 db;
    logic [`RRF_STORE_WIDTH-1:0] saved;
    logic [`RRF_STORE_WIDTH-1:0] mask;
    int                          b1;
    int                          b2;
    int                          errs;
    int                          waited;
    lcg_state = 32'h3f96_8b5d;
    errors = 0;
    tests  = 0;
    failed = 0;
    rst_n   = 1'b0;
    wport_a = '0;
    wport_b = '0;
    raddr_a = '0;
    raddr_b = '0;
    raddr_c = '0;
    start   = 1'b0;
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Everything cleared after reset
    errs = errors;
    check_value("busy", 32'(busy), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_value("restore valid", 32'(restore.valid), 32'd0);
    sweep_reads();
    finish_test("reset", errs);

    // Fill both banks with port A on even and port B on odd addresses
    errs = errors;
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      #5;
      wport_a = '{we: 1'b1, addr: 6'(2 * i), data: lcg_next()};
      wport_b = '{we: 1'b1, addr: 6'(2 * i + 1), data: lcg_next()};
      if (i != 0) begin
        model[2 * i] = wport_a.data;
      end
      model[2 * i + 1] = wport_b.data;
    end
    @(posedge clk);
    #5;
    wport_a.we = 1'b0;
    wport_b.we = 1'b0;
    sweep_reads();
    finish_test("fill", errs);

    foreach (stim[r]) begin
      row  = stim[r];
      errs = errors;
      da   = lcg_next();
      db   = lcg_next();
      @(posedge clk);
      #5;
      wport_a = '{we: row.we_a, addr: row.addr_a, data: da};
      wport_b = '{we: row.we_b, addr: row.addr_b, data: db};
      @(posedge clk);
      #5;
      wport_a.we = 1'b0;
      wport_b.we = 1'b0;
      // Port B is applied last so it wins and address 0 is never stored
      if (row.we_a && row.addr_a != 6'd0) model[row.addr_a] = da;
      if (row.we_b && row.addr_b != 6'd0) model[row.addr_b] = db;
      raddr_a = row.ra;
      raddr_b = row.rb;
      raddr_c = row.rc;
      saved = stored_word(row.ra);
      if (row.flips != 2'd0) begin
        b1   = int'(lcg_next() % 32'd39);
        b2   = (b1 + 1 + int'(lcg_next() % 32'd38)) % 39;
        mask = '0;
        mask[b1] = 1'b1;
        if (row.flips == 2'd2) mask[b2] = 1'b1;
        deposit_word(row.ra, saved ^ mask);
      end
      #1;
      check_port("port a", rdata_a, model[row.ra], row.flips == 2'd1, row.flips == 2'd2,
                 row.flips != 2'd2);
      check_port("port b", rdata_b, model[row.rb], 1'b0, 1'b0, 1'b1);
      check_port("port c", rdata_c, model[row.rc], 1'b0, 1'b0, 1'b1);
      deposit_word(row.ra, saved);
      finish_test($sformatf("row %0d", r), errs);
    end

    // Replay with a second start at register 20 that must be ignored
    errs = errors;
    @(posedge clk);
    #5;
    start = 1'b1;
    @(posedge clk);
    #5;
    start  = 1'b0;
    waited = 0;
    while (!restore.valid && waited < 4) begin
      @(posedge clk);
      #5;
      waited++;
    end
    for (int a = 1; a < 64; a++) begin
      #1;
      check_value("busy", 32'(busy), 32'd1);
      check_value("restore valid", 32'(restore.valid), 32'd1);
      check_value("restore addr", 32'(restore.addr), 32'(a));
      check_value("restore data", restore.data, model[a]);
      check_value("done", 32'(done), 32'd0);
      start = (a == 20);
      @(posedge clk);
      #5;
    end
    start = 1'b0;
    check_value("done", 32'(done), 32'd1);
    check_value("restore valid", 32'(restore.valid), 32'd0);
    @(posedge clk);
    #5;
    check_value("done", 32'(done), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    finish_test("replay", errs);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
logic/rrf_pkg.sv
logic/secded_39_32_enc.sv
logic/secded_39_32_dec.sv
logic/recovery_rf.sv
logic/recovery_seq.sv
logic/recovery_unit.sv
bench/recovery_unit_assert.sv
bench/recovery_unit_tb.sv

/* Makefile */
# Verilator build and run for the rapid-recovery register file

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= recovery_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
